// File: alu.sv
/*
  alu
  arithmetic, logic, shift and compare unit, also the branch conditions
*/
module alu
  import cpuPkg::*;
(
  input  logic [xlen-1:0] opA,
  input  logic [xlen-1:0] opB,
  input  aluOpT           aluOp,
  output logic [xlen-1:0] result
);

  logic [4:0] shamt;
  logic       ltS;
  logic       ltU;

  assign shamt = opB[4:0];
  assign ltS   = $signed(opA) < $signed(opB);
  assign ltU   = opA < opB;

  always_comb begin
    case (aluOp)
      aluAdd:         result = opA + opB;
      aluSub:         result = opA - opB;
      aluSll:         result = opA << shamt;
      aluSlt, aluLt:  result = xlen'(ltS);
      aluSltu, aluLtu: result = xlen'(ltU);
      aluXor:         result = opA ^ opB;
      aluSrl:         result = opA >> shamt;
      aluSra:         result = $unsigned($signed(opA) >>> shamt);
      aluOr:          result = opA | opB;
      aluAnd:         result = opA & opB;
      aluPassB:       result = opB;
      aluEq:          result = xlen'(opA == opB);
      aluNe:          result = xlen'(opA != opB);
      aluGe:          result = xlen'(!ltS);
      aluGeu:         result = xlen'(!ltU);
      default:        result = '0;
    endcase
  end

endmodule

// File: cpuPkg.sv
/*
  cpuPkg
  widths, opcodes, ALU and access codes and the instruction formats
  shared by the two-stage RV32I core
*/
package cpuPkg;

  localparam int xlen   = 32;
  localparam int regIdW = 5;

  // addi x0, x0, 0
  localparam logic [xlen-1:0] nopInst    = 32'h0000_0013;
  localparam logic [xlen-1:0] ebreakInst = 32'h0010_0073;

  // base opcodes
  localparam logic [6:0] opLui    = 7'b0110111;
  localparam logic [6:0] opAuipc  = 7'b0010111;
  localparam logic [6:0] opJal    = 7'b1101111;
  localparam logic [6:0] opJalr   = 7'b1100111;
  localparam logic [6:0] opBranch = 7'b1100011;
  localparam logic [6:0] opLoad   = 7'b0000011;
  localparam logic [6:0] opStore  = 7'b0100011;
  localparam logic [6:0] opImm    = 7'b0010011;
  localparam logic [6:0] opReg    = 7'b0110011;
  localparam logic [6:0] opSystem = 7'b1110011;

  // seventeen operations, so five bits are needed
  typedef enum logic [4:0] {
    aluAdd, aluSub, aluSll, aluSlt, aluSltu,
    aluXor, aluSrl, aluSra, aluOr, aluAnd,
    aluPassB,
    aluEq, aluNe, aluLt, aluGe, aluLtu, aluGeu
  } aluOpT;

  typedef enum logic [1:0] {byteW, halfW, wordW} memWidthT;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2, rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rTypeT;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } iTypeT;

  typedef struct packed {
    logic [6:0] immHi;
    logic [4:0] rs2, rs1;
    logic [2:0] funct3;
    logic [4:0] immLo;
    logic [6:0] opcode;
  } sTypeT;

  typedef struct packed {
    logic       imm12;
    logic [5:0] immHi;
    logic [4:0] rs2, rs1;
    logic [2:0] funct3;
    logic [3:0] immLo;
    logic       imm11;
    logic [6:0] opcode;
  } bTypeT;

  typedef struct packed {
    logic [19:0] immHi;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } uTypeT;

  typedef struct packed {
    logic       imm20;
    logic [9:0] immLo;
    logic       imm11;
    logic [7:0] immMid;
    logic [4:0] rd;
    logic [6:0] opcode;
  } jTypeT;

  typedef union packed {
    rTypeT r;
    iTypeT i;
    sTypeT s;
    bTypeT b;
    uTypeT u;
    jTypeT j;
  } instWordT;

endpackage

// File: cpuTop.f
cpuPkg.sv
decodeIf.sv
fetchUnit.sv
ifIdReg.sv
decoder.sv
regFile.sv
alu.sv
dataMem.sv
cpuTop.sv
cpuTop_sva.sv
cpuTop_tb.sv

// File: cpuTop.sv
/*
  cpuTop
  two-stage RV32I core, fetch then a single decode/execute stage
*/
module cpuTop
  import cpuPkg::*;
#(
  parameter logic [xlen-1:0] pcReset   = '0,
  parameter int              imemWords = 256,
  parameter int              dmemBytes = 1024
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         progWe,
  input  logic [$clog2(imemWords)-1:0] progAddr,
  input  logic [xlen-1:0]              progData,
  input  logic [regIdW-1:0]            dbgRegAddr,
  output logic [xlen-1:0]              dbgRegData,
  output logic [xlen-1:0]              pc,
  output logic                         halted,
  output logic                         illegal
);

  logic [xlen-1:0] pcIf, instIf, pcId, instId;
  logic [xlen-1:0] rs1Data, rs2Data, opA, opB, aluResult, loadData, wbData;
  logic            flush;
  logic            stop;

  decodeIf dec ();

  assign stop = halted || illegal;
  assign pc   = pcIf;

  fetchUnit #(.pcReset(pcReset), .imemWords(imemWords)) u_fetch (
    .clk(clk), .rst(rst), .stop(stop),
    .isBranch(dec.isBranch), .branchTaken(aluResult[0]),
    .isJal(dec.isJal), .isJalr(dec.isJalr), .imm(dec.imm),
    .pcId(pcId), .aluResult(aluResult),
    .progWe(progWe), .progAddr(progAddr), .progData(progData),
    .pcIf(pcIf), .instIf(instIf), .flush(flush)
  );

  ifIdReg u_ifId (
    .clk(clk), .rst(rst), .stop(stop), .flush(flush),
    .pcIf(pcIf), .instIf(instIf), .pcId(pcId), .instId(instId)
  );

  decoder u_dec (.instId(instId), .dec(dec));

  regFile u_regs (
    .clk(clk), .stop(stop), .wdata(wbData), .dbgAddr(dbgRegAddr), .dec(dec),
    .rdata1(rs1Data), .rdata2(rs2Data), .dbgData(dbgRegData)
  );

  // operand muxes
  assign opA = dec.pcAsA ? pcId : rs1Data;
  assign opB = dec.needImm ? dec.imm : rs2Data;

  alu u_alu (.opA(opA), .opB(opB), .aluOp(dec.aluOp), .result(aluResult));

  dataMem #(.dmemBytes(dmemBytes)) u_dmem (
    .clk(clk), .stop(stop), .addr(aluResult), .wdata(rs2Data), .dec(dec),
    .rdata(loadData)
  );

  // link address for jumps, then loads, then ALU
  assign wbData = (dec.isJal || dec.isJalr) ? pcId + xlen'(4)
                : dec.isLoad ? loadData : aluResult;

  // sticky stop levels, cleared only by reset
  always_ff @(posedge clk) begin
    if (rst) begin
      halted  <= 1'b0;
      illegal <= 1'b0;
    end else if (!stop) begin
      halted  <= dec.isEbreak;
      illegal <= dec.isIllegal;
    end
  end

endmodule

// File: cpuTop_sva.sv
/*
  cpuTop_sva
  bound checks on redirect, stop and x0 behavior of the core
*/
module cpuTop_sva
  import cpuPkg::*;
(
  input logic              clk,
  input logic              rst,
  input logic              flush,
  input logic              stop,
  input logic              halted,
  input logic [xlen-1:0]   pc,
  input logic [xlen-1:0]   instId,
  input logic [regIdW-1:0] dbgRegAddr,
  input logic [xlen-1:0]   dbgRegData
);

  // a redirect happens only while running and leaves a NOP bubble in IF/ID
  flushBubble: assert property (@(posedge clk) disable iff (rst)
    flush |=> !$past(stop) && instId == nopInst)
    else $error("flush raised while stopped or did not squash the fetched word");

  haltSticky: assert property (@(posedge clk) disable iff (rst) halted |=> halted)
    else $error("halted dropped without a reset");

  pcFrozen: assert property (@(posedge clk) disable iff (rst) halted |=> $stable(pc))
    else $error("pc moved while the core is halted");

  x0ReadsZero: assert property (@(posedge clk) dbgRegAddr == '0 |-> dbgRegData == '0)
    else $error("debug read of x0 returned a nonzero value");

endmodule

bind cpuTop cpuTop_sva u_sva (
  .clk(clk), .rst(rst), .flush(flush), .stop(stop), .halted(halted), .pc(pc),
  .instId(instId), .dbgRegAddr(dbgRegAddr), .dbgRegData(dbgRegData)
);

// File: cpuTop_tb.sv
/*
  cpuTop_tb
  directed testbench for the two-stage RV32I core, programs are assembled
  here, loaded under reset and checked through the debug read port
*/
module cpuTop_tb
  import cpuPkg::*;
();

  localparam int clkPeriod    = 8;
  localparam int maxCycles    = 300;
  localparam int numTests     = 6;
  localparam int watchdogTime = numTests * maxCycles * clkPeriod;

  logic        clk;
  logic        rst;
  logic        progWe;
  logic [7:0]  progAddr;
  logic [31:0] progData;
  logic [4:0]  dbgRegAddr;
  logic [31:0] dbgRegData;
  logic [31:0] pc;
  logic        halted;
  logic        illegal;

  logic [31:0] prog [$];
  logic [31:0] expVal [32];
  bit          expValid [32];
  logic [7:0]  memModel [12];
  logic [31:0] lfsrState = 32'h30a9;

  cpuTop u_dut (
    .clk(clk), .rst(rst), .progWe(progWe), .progAddr(progAddr), .progData(progData),
    .dbgRegAddr(dbgRegAddr), .dbgRegData(dbgRegData),
    .pc(pc), .halted(halted), .illegal(illegal)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  initial begin
    #(watchdogTime);
    abortRun("watchdog timeout, the tests did not finish in time");
  end

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped on first error");
  endtask

  // x^32 + x^22 + x^2 + x + 1, one step per bit taken
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int k = 0; k < n; k++) begin
      fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
      lfsrState = {lfsrState[30:0], fb};
      val = {val[30:0], fb};
    end
    return val;
  endfunction

  // instruction encoders
  function automatic logic [31:0] encR(input logic [6:0] f7, input int rs2, input int rs1,
                                       input logic [2:0] f3, input int rd);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), opReg};
  endfunction

  function automatic logic [31:0] encI(input int imm, input int rs1, input logic [2:0] f3,
                                       input int rd, input logic [6:0] op);
    return {12'(imm), 5'(rs1), f3, 5'(rd), op};
  endfunction

  function automatic logic [31:0] encS(input int imm, input int rs2, input int rs1,
                                       input logic [2:0] f3);
    logic [11:0] i;
    i = 12'(imm);
    return {i[11:5], 5'(rs2), 5'(rs1), f3, i[4:0], opStore};
  endfunction

  function automatic logic [31:0] encB(input int off, input int rs2, input int rs1,
                                       input logic [2:0] f3);
    logic [12:0] o;
    o = 13'(off);
    return {o[12], o[10:5], 5'(rs2), 5'(rs1), f3, o[4:1], o[11], opBranch};
  endfunction

  function automatic logic [31:0] encU(input logic [19:0] imm, input int rd,
                                       input logic [6:0] op);
    return {imm, 5'(rd), op};
  endfunction

  function automatic logic [31:0] encJ(input int off, input int rd);
    logic [20:0] o;
    o = 21'(off);
    return {o[20], o[10:1], o[11], o[19:12], 5'(rd), opJal};
  endfunction

  function automatic void emit(input logic [31:0] w);
    prog.push_back(w);
  endfunction

  function automatic void addi(input int rd, input int rs1, input int imm);
    emit(encI(imm, rs1, 3'd0, rd, opImm));
  endfunction

  // lui then addi, upper part rounded for the signed low half
  function automatic void loadImm(input int rd, input logic [31:0] v);
    logic [31:0] t;
    t = v + 32'h800;
    emit(encU(t[31:12], rd, opLui));
    addi(rd, rd, int'(v[11:0]));
  endfunction

  function automatic void expectReg(input int r, input logic [31:0] v);
    expVal[r]   = v;
    expValid[r] = 1'b1;
  endfunction

  function automatic void newProgram();
    prog.delete();
    foreach (expValid[r]) expValid[r] = 1'b0;
  endfunction

  function automatic logic [31:0] pcNow();
    return 32'(prog.size() * 4);
  endfunction

  task automatic checkBit(input string test, input string what, input bit exp, input bit act);
    assert (act == exp) else begin
      abortRun($sformatf("ERROR %s %s expected %0b actual %0b", test, what, exp, act));
    end
  endtask

  task automatic checkRegs(input string test);
    for (int r = 0; r < 32; r++) begin
      if (expValid[r]) begin
        @(posedge clk);
        dbgRegAddr <= 5'(r);
        @(negedge clk);
        assert (dbgRegData === expVal[r]) else begin
          abortRun($sformatf("ERROR %s x%0d expected %08h actual %08h",
                             test, r, expVal[r], dbgRegData));
        end
      end
    end
  endtask

  // load under reset, release and wait for the core to stop
  task automatic runProgram(input string test, input bit expIllegal);
    int n;
    int cycles;
    n = (prog.size() > 10) ? prog.size() : 10;
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      rst      <= 1'b1;
      progWe   <= (i < prog.size());
      progAddr <= 8'(i);
      progData <= (i < prog.size()) ? prog[i] : nopInst;
    end
    @(negedge clk);
    assert (pc == '0 && !halted && !illegal) else begin
      abortRun($sformatf("reset did not clear pc, halted and illegal in test %s", test));
    end
    @(posedge clk);
    progWe <= 1'b0;
    rst    <= 1'b0;
    cycles = 0;
    while (!halted && !illegal && cycles < maxCycles) begin
      @(negedge clk);
      cycles++;
    end
    assert (halted || illegal) else begin
      abortRun($sformatf("core did not stop within %0d cycles in test %s", maxCycles, test));
    end
    checkBit(test, "halted", !expIllegal, halted);
    checkBit(test, "illegal", expIllegal, illegal);
  endtask

  function automatic void rOp(input logic [6:0] f7, input logic [2:0] f3, input int rd,
                              input logic [31:0] exp);
    emit(encR(f7, 2, 1, f3, rd));
    expectReg(rd, exp);
  endfunction

  function automatic void iOp(input logic [2:0] f3, input int imm, input int rd,
                              input logic [31:0] exp);
    emit(encI(imm, 1, f3, rd, opImm));
    expectReg(rd, exp);
  endfunction

  task automatic aluTest();
    logic [31:0] a, b, immS, auiPc;
    logic [11:0] i12;
    logic [4:0]  sh;
    logic [19:0] u;
    newProgram();
    a    = randBits(32);
    b    = randBits(32);
    i12  = 12'(randBits(12));
    sh   = 5'(randBits(5));
    u    = 20'(randBits(20));
    immS = {{20{i12[11]}}, i12};
    loadImm(1, a);
    loadImm(2, b);
    rOp(7'h00, 3'd0, 3, a + b);
    rOp(7'h20, 3'd0, 4, a - b);
    rOp(7'h00, 3'd1, 5, a << b[4:0]);
    rOp(7'h00, 3'd2, 6, {31'b0, $signed(a) < $signed(b)});
    rOp(7'h00, 3'd3, 7, {31'b0, a < b});
    rOp(7'h00, 3'd4, 8, a ^ b);
    rOp(7'h00, 3'd5, 9, a >> b[4:0]);
    rOp(7'h20, 3'd5, 10, $signed(a) >>> b[4:0]);
    rOp(7'h00, 3'd6, 11, a | b);
    rOp(7'h00, 3'd7, 12, a & b);
    iOp(3'd0, int'(i12), 13, a + immS);
    iOp(3'd2, int'(i12), 14, {31'b0, $signed(a) < $signed(immS)});
    iOp(3'd3, int'(i12), 15, {31'b0, a < immS});
    iOp(3'd4, int'(i12), 16, a ^ immS);
    iOp(3'd6, int'(i12), 17, a | immS);
    iOp(3'd7, int'(i12), 18, a & immS);
    iOp(3'd1, int'(sh), 19, a << sh);
    iOp(3'd5, int'(sh), 20, a >> sh);
    iOp(3'd5, 'h400 + int'(sh), 21, $signed(a) >>> sh);
    emit(encU(u, 22, opLui));
    expectReg(22, {u, 12'b0});
    auiPc = pcNow();
    emit(encU(u, 23, opAuipc));
    expectReg(23, auiPc + {u, 12'b0});
    emit(ebreakInst);
    runProgram("alu", 1'b0);
    checkRegs("alu");
  endtask

  function automatic void storeOp(input logic [2:0] f3, input int rs2, input int off,
                                  input logic [31:0] val);
    emit(encS(off, rs2, 1, f3));
    for (int k = 0; k < (1 << f3[1:0]); k++) memModel[off + k] = val[8*k +: 8];
  endfunction

  // little-endian gather, sign extension only for lb and lh
  function automatic void loadOp(input logic [2:0] f3, input int off, input int rd);
    logic [31:0] raw;
    logic [31:0] v;
    raw = '0;
    for (int k = 0; k < (1 << f3[1:0]); k++) raw[8*k +: 8] = memModel[off + k];
    case (f3)
      3'd0:    v = {{24{raw[7]}}, raw[7:0]};
      3'd1:    v = {{16{raw[15]}}, raw[15:0]};
      default: v = raw;
    endcase
    emit(encI(off, 1, f3, rd, opLoad));
    expectReg(rd, v);
  endfunction

  task automatic loadStoreTest();
    logic [31:0] w, h, bt;
    int          rd;
    int          bOffs [5];
    newProgram();
    bOffs = '{1, 3, 5, 8, 9};
    w  = randBits(32);
    h  = randBits(32) | 32'h8000;
    bt = randBits(32) | 32'h80;
    loadImm(1, 32'h100);
    loadImm(2, w);
    loadImm(3, h);
    loadImm(4, bt);
    storeOp(3'd2, 2, 0, w);
    storeOp(3'd2, 0, 4, '0);
    storeOp(3'd2, 0, 8, '0);
    storeOp(3'd1, 3, 4, h);
    storeOp(3'd1, 3, 10, h);
    storeOp(3'd0, 4, 5, bt);
    storeOp(3'd0, 4, 8, bt);
    storeOp(3'd0, 3, 3, h);
    rd = 5;
    for (int o = 0; o < 12; o += 4) begin
      loadOp(3'd2, o, rd);
      rd++;
    end
    for (int o = 0; o < 12; o += 2) begin
      loadOp(3'd1, o, rd);
      loadOp(3'd5, o, rd + 1);
      rd += 2;
    end
    foreach (bOffs[k]) begin
      loadOp(3'd0, bOffs[k], rd);
      loadOp(3'd4, bOffs[k], rd + 1);
      rd += 2;
    end
    emit(ebreakInst);
    runProgram("loadStore", 1'b0);
    checkRegs("loadStore");
  endtask

  function automatic bit branchModel(input logic [2:0] f3, input logic [31:0] a,
                                     input logic [31:0] b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic branchTest();
    logic [2:0]  conds [6];
    int          pairA [3];
    int          pairB [3];
    logic [31:0] xa, xb;
    int          mk;
    bit          taken;
    newProgram();
    conds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    pairA = '{1, 2, 1};
    pairB = '{2, 1, 1};
    // x1 negative, x2 positive, so signed and unsigned order differ
    xa = randBits(32) | 32'h8000_0000;
    xb = randBits(32) & 32'h7fff_ffff;
    loadImm(1, xa);
    loadImm(2, xb);
    for (int m = 3; m < 21; m++) addi(m, 0, -1);
    foreach (conds[c]) begin
      for (int p = 0; p < 3; p++) begin
        mk    = 3 + c * 3 + p;
        taken = branchModel(conds[c], (pairA[p] == 1) ? xa : xb, (pairB[p] == 1) ? xa : xb);
        // taken branch skips exactly the flushed marker write
        emit(encB(8, pairB[p], pairA[p], conds[c]));
        addi(mk, 0, mk);
        expectReg(mk, taken ? 32'hffff_ffff : 32'(mk));
      end
    end
    emit(ebreakInst);
    runProgram("branch", 1'b0);
    checkRegs("branch");
  endtask

  task automatic jumpTest();
    logic [31:0] base;
    newProgram();
    addi(5, 0, -1);
    addi(7, 0, -1);
    base = pcNow();
    emit(encJ(8, 1));
    expectReg(1, base + 4);
    addi(5, 0, 1);
    expectReg(5, 32'hffff_ffff);
    addi(6, 0, 2);
    expectReg(6, 2);
    // odd target, bit 0 must be dropped
    addi(2, 0, int'(base) + 25);
    emit(encI(0, 2, 3'd0, 3, opJalr));
    expectReg(3, base + 20);
    addi(7, 0, 3);
    expectReg(7, 32'hffff_ffff);
    emit(encU(20'h0, 9, opAuipc));
    expectReg(9, base + 24);
    addi(8, 0, 4);
    expectReg(8, 4);
    emit(ebreakInst);
    runProgram("jump", 1'b0);
    checkRegs("jump");
  endtask

  task automatic stopTest();
    logic [31:0] pcHalt;
    newProgram();
    addi(5, 0, 11);
    expectReg(5, 11);
    addi(6, 0, 0);
    expectReg(6, 0);
    emit(ebreakInst);
    addi(6, 0, 77);
    runProgram("ebreak", 1'b0);
    pcHalt = pc;
    repeat (20) begin
      @(negedge clk);
      assert (pc == pcHalt) else begin
        abortRun($sformatf("ERROR ebreak pc expected %08h actual %08h", pcHalt, pc));
      end
    end
    checkRegs("ebreak");
    newProgram();
    addi(7, 0, 21);
    expectReg(7, 21);
    addi(8, 0, 0);
    expectReg(8, 0);
    emit(32'hffff_ffff);
    addi(8, 0, 99);
    runProgram("illegal", 1'b1);
    checkRegs("illegal");
  endtask

  // runs after the illegal stop, so its reset must clear both levels
  task automatic x0ResetTest();
    newProgram();
    addi(5, 0, 7);
    emit(encI(123, 0, 3'd0, 0, opImm));
    emit(encU(20'habcde, 0, opLui));
    emit(encR(7'h00, 0, 0, 3'd0, 5));
    addi(6, 0, 55);
    expectReg(0, 0);
    expectReg(5, 0);
    expectReg(6, 55);
    emit(ebreakInst);
    runProgram("x0Reset", 1'b0);
    checkRegs("x0Reset");
  endtask

  initial begin
    rst        = 1'b1;
    progWe     = 1'b0;
    progAddr   = '0;
    progData   = '0;
    dbgRegAddr = '0;
    aluTest();
    loadStoreTest();
    branchTest();
    jumpTest();
    stopTest();
    x0ResetTest();
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// File: dataMem.sv
/*
  dataMem
  byte-addressed data memory, byte-lane writes and little-endian reads
  with sign or zero extension of byte and half loads
*/
module dataMem
  import cpuPkg::*;
#(
  parameter int dmemBytes = 1024
) (
  input  logic            clk,
  input  logic            stop,
  input  logic [xlen-1:0] addr,
  input  logic [xlen-1:0] wdata,
  decodeIf.sink           dec,
  output logic [xlen-1:0] rdata
);

  localparam int idxW = $clog2(dmemBytes);

  logic [7:0]      mem [dmemBytes];
  logic [idxW-1:0] a0, a1, a2, a3;
  logic [xlen-1:0] raw;

  // low address bits used as is, wrapping at the top
  assign a0 = addr[idxW-1:0];
  assign a1 = a0 + idxW'(1);
  assign a2 = a0 + idxW'(2);
  assign a3 = a0 + idxW'(3);

  always_ff @(posedge clk) begin
    if (dec.memWen && !stop) begin
      mem[a0] <= wdata[7:0];
      if (dec.memWidth != byteW) begin
        mem[a1] <= wdata[15:8];
      end
      if (dec.memWidth == wordW) begin
        mem[a2] <= wdata[23:16];
        mem[a3] <= wdata[31:24];
      end
    end
  end

  assign raw = {mem[a3], mem[a2], mem[a1], mem[a0]};

  // load extension
  always_comb begin
    case (dec.memWidth)
      byteW:   rdata = {{24{!dec.isUnsigned && raw[7]}}, raw[7:0]};
      halfW:   rdata = {{16{!dec.isUnsigned && raw[15]}}, raw[15:0]};
      default: rdata = raw;
    endcase
  end

endmodule

// File: decodeIf.sv
/*
  decodeIf
  decoded control bundle from the decoder to the execute consumers
*/
interface decodeIf
  import cpuPkg::*;
();

  logic [regIdW-1:0] rd, rs1, rs2;
  logic [xlen-1:0]   imm;
  aluOpT             aluOp;
  memWidthT          memWidth;
  logic regWen, memWen, isLoad, isUnsigned, needImm, pcAsA;
  logic isBranch, isJal, isJalr, isEbreak, isIllegal;

  modport source (
    output rd, rs1, rs2, imm, aluOp, memWidth,
    output regWen, memWen, isLoad, isUnsigned, needImm, pcAsA,
    output isBranch, isJal, isJalr, isEbreak, isIllegal
  );

  modport sink (
    input rd, rs1, rs2, imm, aluOp, memWidth,
    input regWen, memWen, isLoad, isUnsigned, needImm, pcAsA,
    input isBranch, isJal, isJalr, isEbreak, isIllegal
  );

endinterface

// File: decoder.sv
/*
  decoder
  splits an RV32I word into register indexes, immediate, ALU operation,
  access width and control flags; flags unknown encodings as illegal
*/
module decoder
  import cpuPkg::*;
(
  input instWordT instId,
  decodeIf.source dec
);

  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       legal;

  assign funct3  = instId.r.funct3;
  assign funct7  = instId.r.funct7;
  // register fields sit at the same place in every format
  assign dec.rd  = instId.r.rd;
  assign dec.rs1 = instId.r.rs1;
  assign dec.rs2 = instId.r.rs2;

  always_comb begin
    dec.imm        = '0;
    dec.aluOp      = aluAdd;
    dec.memWidth   = wordW;
    dec.regWen     = 1'b0;
    dec.memWen     = 1'b0;
    dec.isLoad     = 1'b0;
    dec.isUnsigned = 1'b0;
    dec.needImm    = 1'b0;
    dec.pcAsA      = 1'b0;
    dec.isBranch   = 1'b0;
    dec.isJal      = 1'b0;
    dec.isJalr     = 1'b0;
    dec.isEbreak   = 1'b0;
    legal          = 1'b1;

    case (instId.r.opcode)
      opLui, opAuipc: begin
        dec.imm     = {instId.u.immHi, 12'b0};
        dec.aluOp   = (instId.u.opcode == opLui) ? aluPassB : aluAdd;
        dec.pcAsA   = (instId.u.opcode == opAuipc);
        dec.needImm = 1'b1;
        dec.regWen  = 1'b1;
      end
      opJal: begin
        dec.imm     = {{11{instId.j.imm20}}, instId.j.imm20, instId.j.immMid,
                       instId.j.imm11, instId.j.immLo, 1'b0};
        dec.pcAsA   = 1'b1;
        dec.needImm = 1'b1;
        dec.regWen  = 1'b1;
        dec.isJal   = 1'b1;
      end
      opJalr: begin
        dec.imm     = {{20{instId.i.imm[11]}}, instId.i.imm};
        dec.needImm = 1'b1;
        dec.regWen  = 1'b1;
        dec.isJalr  = 1'b1;
        legal       = (funct3 == 3'b000);
      end
      opBranch: begin
        dec.imm      = {{19{instId.b.imm12}}, instId.b.imm12, instId.b.imm11,
                        instId.b.immHi, instId.b.immLo, 1'b0};
        dec.isBranch = 1'b1;
        case (funct3)
          3'b000:  dec.aluOp = aluEq;
          3'b001:  dec.aluOp = aluNe;
          3'b100:  dec.aluOp = aluLt;
          3'b101:  dec.aluOp = aluGe;
          3'b110:  dec.aluOp = aluLtu;
          3'b111:  dec.aluOp = aluGeu;
          default: legal = 1'b0;
        endcase
      end
      opLoad, opStore: begin
        dec.needImm    = 1'b1;
        dec.isLoad     = (instId.r.opcode == opLoad);
        dec.regWen     = dec.isLoad;
        dec.memWen     = !dec.isLoad;
        dec.isUnsigned = funct3[2];
        dec.imm        = dec.isLoad ? {{20{instId.i.imm[11]}}, instId.i.imm}
                                    : {{20{instId.s.immHi[6]}}, instId.s.immHi,
                                       instId.s.immLo};
        case (funct3[1:0])
          2'b00:   dec.memWidth = byteW;
          2'b01:   dec.memWidth = halfW;
          2'b10:   dec.memWidth = wordW;
          default: legal = 1'b0;
        endcase
        // no unsigned word load and no unsigned store
        if (funct3[2] && (!dec.isLoad || funct3[1])) begin
          legal = 1'b0;
        end
      end
      opImm, opReg: begin
        dec.needImm = (instId.r.opcode == opImm);
        dec.regWen  = 1'b1;
        dec.imm     = {{20{instId.i.imm[11]}}, instId.i.imm};
        case (funct3)
          3'b000:  dec.aluOp = (!dec.needImm && funct7[5]) ? aluSub : aluAdd;
          3'b001:  dec.aluOp = aluSll;
          3'b010:  dec.aluOp = aluSlt;
          3'b011:  dec.aluOp = aluSltu;
          3'b100:  dec.aluOp = aluXor;
          3'b101:  dec.aluOp = funct7[5] ? aluSra : aluSrl;
          3'b110:  dec.aluOp = aluOr;
          default: dec.aluOp = aluAnd;
        endcase
        // funct7 matters for all register ops but only the immediate shifts
        if (!dec.needImm || funct3 == 3'b001 || funct3 == 3'b101) begin
          legal = (funct7 == 7'b0) || (funct7 == 7'b0100000 &&
                  (funct3 == 3'b101 || (funct3 == 3'b000 && !dec.needImm)));
        end
      end
      opSystem: begin
        dec.isEbreak = (instId == ebreakInst);
        legal        = dec.isEbreak;
      end
      default: legal = 1'b0;
    endcase

    dec.isIllegal = !legal;
    if (!legal) begin
      dec.regWen = 1'b0;
      dec.memWen = 1'b0;
    end
  end

endmodule

// File: fetchUnit.sv
/*
  fetchUnit
  PC register, next-PC selection and flush, plus the program memory
  with its load port
*/
module fetchUnit
  import cpuPkg::*;
#(
  parameter logic [xlen-1:0] pcReset   = '0,
  parameter int              imemWords = 256
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         stop,
  input  logic                         isBranch,
  input  logic                         branchTaken,
  input  logic                         isJal,
  input  logic                         isJalr,
  input  logic [xlen-1:0]              imm,
  input  logic [xlen-1:0]              pcId,
  input  logic [xlen-1:0]              aluResult,
  input  logic                         progWe,
  input  logic [$clog2(imemWords)-1:0] progAddr,
  input  logic [xlen-1:0]              progData,
  output logic [xlen-1:0]              pcIf,
  output logic [xlen-1:0]              instIf,
  output logic                         flush
);

  localparam int idxW = $clog2(imemWords);

  logic [xlen-1:0] imem [imemWords];
  logic [xlen-1:0] pcNext;
  logic            taken;
  logic            jump;

  assign taken = isBranch && branchTaken;
  assign jump  = isJal || isJalr;
  // no redirect once the core has stopped
  assign flush = !stop && (taken || jump);

  always_comb begin
    if (jump) begin
      pcNext = {aluResult[xlen-1:1], 1'b0};
    end else if (taken) begin
      pcNext = pcId + imm;
    end else begin
      pcNext = pcIf + xlen'(4);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pcIf <= pcReset;
    end else if (!stop) begin
      pcIf <= pcNext;
    end
  end

  // program load, normally under reset
  always_ff @(posedge clk) begin
    if (progWe) begin
      imem[progAddr] <= progData;
    end
  end

  // word-indexed, low two bits ignored
  assign instIf = imem[pcIf[idxW+1:2]];

endmodule

// File: ifIdReg.sv
/*
  ifIdReg
  IF/ID register for the PC and instruction, NOP on reset or flush
*/
module ifIdReg
  import cpuPkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  logic            stop,
  input  logic            flush,
  input  logic [xlen-1:0] pcIf,
  input  logic [xlen-1:0] instIf,
  output logic [xlen-1:0] pcId,
  output logic [xlen-1:0] instId
);

  always_ff @(posedge clk) begin
    if (rst) begin
      pcId   <= '0;
      instId <= nopInst;
    end else if (!stop) begin
      pcId   <= pcIf;
      // squash the wrong-path word behind a redirect
      instId <= flush ? nopInst : instIf;
    end
  end

endmodule

// File: regFile.sv
/*
  regFile
  32 x 32 register file, x0 hardwired to zero, two read ports,
  a debug read port and one write port
*/
module regFile
  import cpuPkg::*;
(
  input  logic              clk,
  input  logic              stop,
  input  logic [xlen-1:0]   wdata,
  input  logic [regIdW-1:0] dbgAddr,
  decodeIf.sink             dec,
  output logic [xlen-1:0]   rdata1,
  output logic [xlen-1:0]   rdata2,
  output logic [xlen-1:0]   dbgData
);

  logic [xlen-1:0] regs [2**regIdW];

  // asynchronous reads, x0 forced to zero
  assign rdata1  = (dec.rs1 == '0) ? '0 : regs[dec.rs1];
  assign rdata2  = (dec.rs2 == '0) ? '0 : regs[dec.rs2];
  assign dbgData = (dbgAddr == '0) ? '0 : regs[dbgAddr];

  // write at the edge that ends the execute cycle
  always_ff @(posedge clk) begin
    if (dec.regWen && dec.rd != '0 && !stop) begin
      regs[dec.rd] <= wdata;
    end
  end

endmodule

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator, exit status is the verdict
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f cpuTop.f --top-module cpuTop_tb \
  --Mdir obj_dir -o simv &&
./obj_dir/simv || { echo "simulation run ended with an error"; exit 1; }
